//--- src/core_cfg.svh
////////////////////////////////////////
// memories are word addressed, the host map is in bytes
// bases must stay aligned to their region size
////////////////////////////////////////
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_WORD_W     32
`define CORE_IMEM_WORDS 256
`define CORE_DMEM_WORDS 64
`define CORE_AXI_ADDR_W 12

`define CORE_MAP_IMEM   'h000   // write side of region 0
`define CORE_MAP_REGS   'h000   // read side of region 0
`define CORE_MAP_CTRL   'h400
`define CORE_MAP_DMEM   'h800

`endif

//--- src/isa_pkg.sv
////////////////////////////////////////
// subset only: add sub and or slt addi lw sw beq bne
////////////////////////////////////////
`default_nettype none

package isa_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // immediate is the low 16 bits, rd..funct
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
////////////////////////////////////////
// all-zero payload is a nop in every stage
////////////////////////////////////////
`default_nettype none
`include "core_cfg.svh"

package pipe_pkg;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic alu_src_imm;
        logic dst_rd;      // rd for R-type, rt otherwise
        logic branch_eq;
        logic branch_ne;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        isa_pkg::instr_t         instr;
        logic [`CORE_WORD_W-1:0] rs_val;
        logic [`CORE_WORD_W-1:0] rt_val;
        logic [`CORE_WORD_W-1:0] imm;   // sign extended
        logic [4:0]              dst;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`CORE_WORD_W-1:0] alu_result;
        logic [`CORE_WORD_W-1:0] store_data;
        logic [4:0]              dst;
    } ex_mem_t;

    typedef struct packed {
        logic                    reg_write;
        logic [4:0]              dst;
        logic [`CORE_WORD_W-1:0] value;
    } mem_wb_t;

    // host to core
    typedef struct packed {
        logic                        awvalid;
        logic [`CORE_AXI_ADDR_W-1:0] awaddr;
        logic                        wvalid;
        logic [`CORE_WORD_W-1:0]     wdata;
        logic                        bready;
        logic                        arvalid;
        logic [`CORE_AXI_ADDR_W-1:0] araddr;
        logic                        rready;
    } axil_req_t;

    // core to host
    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic                    bvalid;
        logic [1:0]              bresp;
        logic                    arready;
        logic                    rvalid;
        logic [`CORE_WORD_W-1:0] rdata;
        logic [1:0]              rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- src/stage_reg.sv
////////////////////////////////////////
// flush and reset both load a nop
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     SYS_clk,
    input  logic     SYS_reset,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || flush)
            q <= '0;
        else
            q <= d;
    end

endmodule

`default_nettype wire

//--- src/axil_host_port.sv
////////////////////////////////////////
// one write and one read outstanding, no wstrb
// program loads only while stopped
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module axil_host_port (
    input  logic                                 SYS_clk,
    input  logic                                 SYS_reset,
    input  pipe_pkg::axil_req_t                  req,
    output pipe_pkg::axil_rsp_t                  rsp,
    output logic                                 run,
    output logic                                 imem_we,
    output logic [$clog2(`CORE_IMEM_WORDS)-1:0]  imem_waddr,
    output logic [31:0]                          imem_wdata,
    output logic [4:0]                           reg_dbg_addr,
    input  logic [31:0]                          reg_dbg_data,
    output logic [$clog2(`CORE_DMEM_WORDS)-1:0]  dmem_dbg_addr,
    input  logic [31:0]                          dmem_dbg_data
);
    import pipe_pkg::*;

    localparam int IW = $clog2(`CORE_IMEM_WORDS);
    localparam int DW = $clog2(`CORE_DMEM_WORDS);

    logic        aw_rdy;
    logic        ar_rdy;
    logic        bvalid;
    logic        rvalid;
    logic        rvalid_n;
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    logic [1:0]  rd_resp;
    logic [31:0] rdata;
    logic [31:0] rd_value;
    logic        wr_fire;
    logic        rd_fire;
    logic        wr_imem;
    logic        wr_ctrl;

    function automatic logic in_region(input logic [`CORE_AXI_ADDR_W-1:0] a,
                                       input int base, input int bytes);
        return (a >= base) && (a < base + bytes);
    endfunction

    assign wr_fire = aw_rdy && req.awvalid && req.wvalid;
    assign rd_fire = ar_rdy && req.arvalid;
    assign wr_imem = in_region(req.awaddr, `CORE_MAP_IMEM, `CORE_IMEM_WORDS * 4);
    assign wr_ctrl = in_region(req.awaddr, `CORE_MAP_CTRL, 4);

    assign imem_we       = wr_fire && wr_imem && !run;   // dropped while running
    assign imem_waddr    = req.awaddr[IW+1:2];
    assign imem_wdata    = req.wdata;
    assign reg_dbg_addr  = req.araddr[6:2];
    assign dmem_dbg_addr = req.araddr[DW+1:2];

    always_comb
    begin
        rd_value = '0;
        rd_resp  = RESP_SLVERR;   // unmapped
        if (in_region(req.araddr, `CORE_MAP_REGS, 32 * 4))
        begin
            rd_value = reg_dbg_data;
            rd_resp  = RESP_OKAY;
        end
        else if (in_region(req.araddr, `CORE_MAP_CTRL, 4))
        begin
            rd_value = {31'd0, run};
            rd_resp  = RESP_OKAY;
        end
        else if (in_region(req.araddr, `CORE_MAP_DMEM, `CORE_DMEM_WORDS * 4))
        begin
            rd_value = dmem_dbg_data;
            rd_resp  = RESP_OKAY;
        end
    end

    assign rvalid_n = rd_fire ? 1'b1 : (rvalid && req.rready) ? 1'b0 : rvalid;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            run    <= 1'b0;
            aw_rdy <= 1'b0;
            ar_rdy <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end
        else
        begin
            aw_rdy <= req.awvalid && req.wvalid && !bvalid && !aw_rdy;   // one-cycle pulse
            if (wr_fire)
                bvalid <= 1'b1;
            else if (req.bready)
                bvalid <= 1'b0;
            if (wr_fire && wr_ctrl)
                run <= req.wdata[0];
            rvalid <= rvalid_n;
            ar_rdy <= !rvalid_n;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wr_fire)
            bresp <= ((wr_imem && !run) || wr_ctrl) ? RESP_OKAY : RESP_SLVERR;
        if (rd_fire)
        begin
            rdata <= rd_value;   // held until rready
            rresp <= rd_resp;
        end
    end

    always_comb
    begin
        rsp.awready = aw_rdy;
        rsp.wready  = aw_rdy;
        rsp.bvalid  = bvalid;
        rsp.bresp   = bresp;
        rsp.arready = ar_rdy;
        rsp.rvalid  = rvalid;
        rsp.rdata   = rdata;
        rsp.rresp   = rresp;
    end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
////////////////////////////////////////
// PC parked at 0 while stopped, no delay slot
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module fetch_unit (
    input  logic                                SYS_clk,
    input  logic                                SYS_reset,
    input  logic                                run,
    input  logic                                stall,
    input  logic                                branch_taken,
    input  logic [31:0]                         branch_target,
    input  logic                                imem_we,
    input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] imem_waddr,
    input  logic [31:0]                         imem_wdata,
    output logic [31:0]                         pc,
    output isa_pkg::instr_t                     instr
);
    import isa_pkg::*;

    localparam int IW = $clog2(`CORE_IMEM_WORDS);

    logic [`CORE_WORD_W-1:0] imem [`CORE_IMEM_WORDS];

    always_ff @(posedge SYS_clk)
    begin
        if (imem_we)
            imem[imem_waddr] <= imem_wdata;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !run)
            pc <= '0;
        else if (branch_taken)
            pc <= branch_target;   // redirect wins over stall
        else if (!stall)
            pc <= pc + 32'd4;
    end

    // nop while stopped or when the slot behind a taken branch is flushed
    assign instr = (!run || branch_taken) ? instr_t'('0) : instr_t'(imem[pc[IW+1:2]]);

endmodule

`default_nettype wire

//--- src/decode_unit.sv
////////////////////////////////////////
// no forwarding, stalls until the producer reaches WB
// branches resolve here against write-first reads
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  isa_pkg::instr_t   f_instr,
    input  logic [31:0]       f_pc,
    input  pipe_pkg::ex_mem_t ex_hazard,
    input  pipe_pkg::ex_mem_t mem_hazard,
    input  pipe_pkg::mem_wb_t wb,
    input  logic [4:0]        reg_dbg_addr,
    output logic [31:0]       reg_dbg_data,
    output pipe_pkg::id_ex_t  id_ex,
    output logic              stall,
    output logic              branch_taken,
    output logic [31:0]       branch_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    instr_t      d_instr;
    logic [31:0] d_pc;
    ctrl_t       ctrl;
    logic [31:0] regs [32];
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm;
    logic        uses_rt;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            d_instr <= '0;
            d_pc    <= '0;
        end
        else if (!stall)
        begin
            d_instr <= f_instr;
            d_pc    <= f_pc;
        end
    end

    always_comb
    begin
        ctrl = '0;
        case (d_instr.opcode)
            OP_RTYPE: {ctrl.reg_write, ctrl.dst_rd} = 2'b11;
            OP_ADDI:  {ctrl.reg_write, ctrl.alu_src_imm} = 2'b11;
            OP_LW:    {ctrl.reg_write, ctrl.mem_read, ctrl.mem_to_reg, ctrl.alu_src_imm} = 4'hf;
            OP_SW:    {ctrl.mem_write, ctrl.alu_src_imm} = 2'b11;
            OP_BEQ:   ctrl.branch_eq = 1'b1;
            OP_BNE:   ctrl.branch_ne = 1'b1;
            default:  ctrl = '0;   // unknown opcode runs as nop
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wb.reg_write && wb.dst != 5'd0)
            regs[wb.dst] <= wb.value;
    end

    // r0 reads zero, WB value bypasses the array
    function automatic logic [31:0] rf_read(input logic [4:0] a);
        logic [31:0] v;
        if (a == 5'd0)
            v = '0;
        else if (wb.reg_write && wb.dst == a)
            v = wb.value;
        else
            v = regs[a];
        return v;
    endfunction

    function automatic logic hits(input ex_mem_t p);
        return p.ctrl.reg_write && p.dst != 5'd0 &&
               (p.dst == d_instr.rs || (uses_rt && p.dst == d_instr.rt));
    endfunction

    always_comb
    begin
        uses_rt      = ctrl.dst_rd || ctrl.mem_write || ctrl.branch_eq || ctrl.branch_ne;
        rs_val       = rf_read(d_instr.rs);
        rt_val       = rf_read(d_instr.rt);
        reg_dbg_data = rf_read(reg_dbg_addr);
        stall        = hits(ex_hazard) || hits(mem_hazard);
    end

    assign imm           = {{16{d_instr[15]}}, d_instr[15:0]};
    assign branch_target = d_pc + 32'd4 + {imm[29:0], 2'b00};
    assign branch_taken  = !stall && ((ctrl.branch_eq && rs_val == rt_val) ||
                                      (ctrl.branch_ne && rs_val != rt_val));

    always_comb
    begin
        id_ex.ctrl   = ctrl;
        id_ex.instr  = d_instr;
        id_ex.rs_val = rs_val;
        id_ex.rt_val = rt_val;
        id_ex.imm    = imm;
        id_ex.dst    = ctrl.dst_rd ? d_instr.rd : d_instr.rt;
    end

endmodule

`default_nettype wire

//--- src/execute_unit.sv
////////////////////////////////////////
// slt is signed, non R-type ops add
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  pipe_pkg::id_ex_t  id_ex,
    output pipe_pkg::ex_mem_t ex_mem
);
    import isa_pkg::*;
    import pipe_pkg::*;

    alu_op_t     alu_op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;

    always_comb
    begin
        alu_op = ALU_ADD;   // addi, lw, sw address
        if (id_ex.instr.opcode == OP_RTYPE)
        begin
            case (id_ex.instr.funct)
                FN_SUB:  alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_SLT:  alu_op = ALU_SLT;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign a = id_ex.rs_val;
    assign b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_val;

    always_comb
    begin
        case (alu_op)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    always_comb
    begin
        ex_mem.ctrl       = id_ex.ctrl;
        ex_mem.alu_result = result;
        ex_mem.store_data = id_ex.rt_val;
        ex_mem.dst        = id_ex.dst;
    end

endmodule

`default_nettype wire

//--- src/memory_unit.sv
////////////////////////////////////////
// word access only, address bits 1:0 ignored
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module memory_unit (
    input  logic                                SYS_clk,
    input  pipe_pkg::ex_mem_t                   ex_mem,
    input  logic [$clog2(`CORE_DMEM_WORDS)-1:0] dmem_dbg_addr,
    output logic [31:0]                         dmem_dbg_data,
    output pipe_pkg::mem_wb_t                   mem_wb
);
    import pipe_pkg::*;

    localparam int DW = $clog2(`CORE_DMEM_WORDS);

    logic [`CORE_WORD_W-1:0] dmem [`CORE_DMEM_WORDS];
    logic [DW-1:0]           idx;
    logic [31:0]             load_data;

    assign idx = ex_mem.alu_result[DW+1:2];

    always_ff @(posedge SYS_clk)
    begin
        if (ex_mem.ctrl.mem_write)
            dmem[idx] <= ex_mem.store_data;
    end

    assign load_data     = dmem[idx];   // async read
    assign dmem_dbg_data = dmem[dmem_dbg_addr];

    always_comb
    begin
        mem_wb.reg_write = ex_mem.ctrl.reg_write;
        mem_wb.dst       = ex_mem.dst;
        mem_wb.value     = ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result;
    end

endmodule

`default_nettype wire

//--- src/mips_core_top.sv
////////////////////////////////////////
// host loads imem while stopped, then sets CTRL.run
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module mips_core_top (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  pipe_pkg::axil_req_t s_axil_req,
    output pipe_pkg::axil_rsp_t s_axil_rsp
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int IW = $clog2(`CORE_IMEM_WORDS);
    localparam int DW = $clog2(`CORE_DMEM_WORDS);

    logic          run;
    logic          imem_we;
    logic [IW-1:0] imem_waddr;
    logic [31:0]   imem_wdata;
    logic [4:0]    reg_dbg_addr;
    logic [31:0]   reg_dbg_data;
    logic [DW-1:0] dmem_dbg_addr;
    logic [31:0]   dmem_dbg_data;
    logic          stall;
    logic          branch_taken;
    logic [31:0]   branch_target;
    logic [31:0]   f_pc;
    instr_t        f_instr;
    id_ex_t        id_ex_d;
    id_ex_t        id_ex_q;
    ex_mem_t       ex_mem_d;
    ex_mem_t       ex_mem_q;
    ex_mem_t       ex_hazard;
    mem_wb_t       mem_wb_d;
    mem_wb_t       mem_wb_q;

    // EX producer seen by the hazard check, only ctrl and dst matter
    assign ex_hazard = '{ctrl: id_ex_q.ctrl, alu_result: '0, store_data: '0, dst: id_ex_q.dst};

    axil_host_port host (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .req           (s_axil_req),
        .rsp           (s_axil_rsp),
        .run           (run),
        .imem_we       (imem_we),
        .imem_waddr    (imem_waddr),
        .imem_wdata    (imem_wdata),
        .reg_dbg_addr  (reg_dbg_addr),
        .reg_dbg_data  (reg_dbg_data),
        .dmem_dbg_addr (dmem_dbg_addr),
        .dmem_dbg_data (dmem_dbg_data)
    );

    fetch_unit fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .run           (run),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_we       (imem_we),
        .imem_waddr    (imem_waddr),
        .imem_wdata    (imem_wdata),
        .pc            (f_pc),
        .instr         (f_instr)
    );

    decode_unit decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .f_instr       (f_instr),
        .f_pc          (f_pc),
        .ex_hazard     (ex_hazard),
        .mem_hazard    (ex_mem_q),
        .wb            (mem_wb_q),
        .reg_dbg_addr  (reg_dbg_addr),
        .reg_dbg_data  (reg_dbg_data),
        .id_ex         (id_ex_d),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .flush     (stall),   // bubble into EX
        .d         (id_ex_d),
        .q         (id_ex_q)
    );

    execute_unit execute (
        .id_ex  (id_ex_q),
        .ex_mem (ex_mem_d)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .flush     (1'b0),
        .d         (ex_mem_d),
        .q         (ex_mem_q)
    );

    memory_unit memory (
        .SYS_clk       (SYS_clk),
        .ex_mem        (ex_mem_q),
        .dmem_dbg_addr (dmem_dbg_addr),
        .dmem_dbg_data (dmem_dbg_data),
        .mem_wb        (mem_wb_d)
    );

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .flush     (1'b0),
        .d         (mem_wb_d),
        .q         (mem_wb_q)
    );

endmodule

`default_nettype wire

//--- verif/tb_mips_model.svh
////////////////////////////////////////
// included in the testbench body after import isa_pkg::*
// model stops at the first beq r0,r0,-1 and has no pipeline
////////////////////////////////////////
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

logic [31:0] lcg_state;
logic [31:0] prog [`CORE_IMEM_WORDS];
int          prog_len = 0;
logic [31:0] exp_regs [32];
logic [31:0] exp_dmem [`CORE_DMEM_WORDS];
logic        exp_dmem_set [`CORE_DMEM_WORDS];

function automatic logic [31:0] rand_bits();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = rand_bits();
    return 5'(1 + r[31:16] % 31);   // never r0
endfunction

function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [5:0] pick_funct(input int sel);
    case (sel)
        0:       return FN_ADD;
        1:       return FN_SUB;
        2:       return FN_AND;
        3:       return FN_OR;
        default: return FN_SLT;
    endcase
endfunction

task automatic emit_word(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
endtask

task automatic build_program();
    logic [31:0] r;
    logic [4:0]  prev;
    logic [4:0]  prev2;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rs;
    int          i;
    int          k;
    int          j;
    int          x;
    int          y;
    lcg_state = 32'h4737_862a;
    prog_len  = 0;
    for (i = 1; i < 32; i++)
    begin
        r = rand_bits();
        emit_word(encode_i(OP_ADDI, 5'(i), 5'd0, r[31:16]));   // every register defined
    end
    // chain reads the last two results, so EX and MEM producers both stall it
    prev  = rand_reg();
    prev2 = rand_reg();
    for (i = 0; i < 10; i++)
    begin
        r  = rand_bits();
        rd = rand_reg();
        if (r[10:8] % 6 == 5)
            emit_word(encode_i(OP_ADDI, rd, prev, r[31:16]));
        else
            emit_word(encode_r(pick_funct(r[10:8] % 6), rd, prev, prev2));
        prev2 = prev;
        prev  = rd;
    end
    for (i = 0; i < 4; i++)
    begin
        rb = rand_reg();
        rs = rand_reg();
        rd = rand_reg();
        k  = (rand_bits() >> 16) % 32;
        j  = (rand_bits() >> 16) % 32;
        emit_word(encode_i(OP_ADDI, rb, 5'd0, 16'(4 * k)));
        emit_word(encode_i(OP_SW, rs, rb, 16'(4 * j)));
        emit_word(encode_i(OP_LW, rd, rb, 16'(4 * j)));
        emit_word(encode_r(FN_ADD, rand_reg(), rd, rd));   // load use
    end
    // beq equal, beq unequal, bne unequal, bne equal
    for (i = 0; i < 4; i++)
    begin
        ra = 5'(1 + (rand_bits() >> 16) % 28);
        rb = ra + 5'd1;
        x  = (rand_bits() >> 16) % 1000;
        y  = (i == 0 || i == 3) ? x : x + 1 + (rand_bits() >> 16) % 100;
        emit_word(encode_i(OP_ADDI, ra, 5'd0, 16'(x)));
        emit_word(encode_i(OP_ADDI, rb, 5'd0, 16'(y)));
        emit_word(encode_i((i < 2) ? OP_BEQ : OP_BNE, rb, ra, 16'd1));
        emit_word(encode_i(OP_ADDI, ra + 5'd2, 5'd0, 16'(16'h0100 + i)));   // fall-through marker
        emit_word(encode_i(OP_ADDI, ra + 5'd3, 5'd0, 16'(16'h0200 + i)));   // join marker
    end
    emit_word(encode_i(OP_BEQ, 5'd0, 5'd0, 16'hffff));
endtask

// fills exp_regs and exp_dmem, returns the executed instruction count
function automatic int run_model();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [4:0]  rd;
    int          idx;
    int          pc;
    int          next;
    int          n;
    int          i;
    for (i = 0; i < 32; i++)
        exp_regs[i] = '0;
    for (i = 0; i < `CORE_DMEM_WORDS; i++)
    begin
        exp_dmem[i]     = '0;
        exp_dmem_set[i] = 1'b0;
    end
    pc = 0;
    n  = 0;
    while (pc < prog_len && n < 4096)
    begin
        w = prog[pc];
        if (w == encode_i(OP_BEQ, 5'd0, 5'd0, 16'hffff))
            break;
        a    = exp_regs[w[25:21]];
        b    = exp_regs[w[20:16]];
        rd   = w[15:11];
        simm = {{16{w[15]}}, w[15:0]};
        idx  = ((a + simm) >> 2) % `CORE_DMEM_WORDS;
        next = pc + 1;
        n++;
        case (w[31:26])
            OP_RTYPE:
            begin
                case (w[5:0])
                    FN_ADD:  exp_regs[rd] = a + b;
                    FN_SUB:  exp_regs[rd] = a - b;
                    FN_AND:  exp_regs[rd] = a & b;
                    FN_OR:   exp_regs[rd] = a | b;
                    FN_SLT:  exp_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ;
                endcase
            end
            OP_ADDI: exp_regs[w[20:16]] = a + simm;
            OP_LW:   exp_regs[w[20:16]] = exp_dmem[idx];
            OP_SW:
            begin
                exp_dmem[idx]     = b;
                exp_dmem_set[idx] = 1'b1;
            end
            OP_BEQ:  next = (a == b) ? pc + 1 + $signed(simm) : next;
            OP_BNE:  next = (a != b) ? pc + 1 + $signed(simm) : next;
            default: ;
        endcase
        exp_regs[0] = '0;
        pc = next;
    end
    return n;
endfunction

`endif

//--- verif/tb_mips_core.sv
////////////////////////////////////////
// drives the core only through its AXI4-Lite port
// one host transaction at a time
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module tb_mips_core;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int HS_LIMIT = 32;   // cycles allowed per handshake

    logic      SYS_clk = 1'b0;
    logic      SYS_reset = 1'b1;
    axil_req_t req = '0;
    axil_rsp_t rsp;
    int        mismatches = 0;
    int        failures = 0;
    int        n_exec = 0;
    event      state_ready;

    `include "tb_mips_model.svh"

    mips_core_top dut (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .s_axil_req (req),
        .s_axil_rsp (rsp)
    );

    always #2 SYS_clk = ~SYS_clk;   // 4 ns period

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        mismatches++;
    endtask

    task automatic axil_write(input logic [`CORE_AXI_ADDR_W-1:0] addr,
                              input logic [31:0] data, output logic [1:0] resp);
        int n;
        @(posedge SYS_clk);
        #1;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        n = 0;
        do
        begin
            @(posedge SYS_clk);
            #1;
            n++;
        end
        while (!(rsp.awready && rsp.wready) && n < HS_LIMIT);
        if (!(rsp.awready && rsp.wready))
        begin
            $display("write to address %h was never accepted", addr);
            failures++;
        end
        @(posedge SYS_clk);   // accepted on this edge
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        n = 0;
        while (!rsp.bvalid && n < HS_LIMIT)
        begin
            @(posedge SYS_clk);
            #1;
            n++;
        end
        if (!rsp.bvalid)
        begin
            $display("write to address %h got no response", addr);
            failures++;
        end
        resp = rsp.bresp;
        req.bready = 1'b1;
        @(posedge SYS_clk);
        #1;
        req.bready = 1'b0;
    endtask

    // hold keeps rready low for that many cycles after rvalid
    task automatic axil_read(input logic [`CORE_AXI_ADDR_W-1:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        int n;
        @(posedge SYS_clk);
        #1;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        n = 0;
        while (!rsp.arready && n < HS_LIMIT)
        begin
            @(posedge SYS_clk);
            #1;
            n++;
        end
        if (!rsp.arready)
        begin
            $display("read of address %h was never accepted", addr);
            failures++;
        end
        @(posedge SYS_clk);   // address taken on this edge
        #1;
        req.arvalid = 1'b0;
        if (hold > 0)
            req.araddr = `CORE_MAP_CTRL;   // bus moves on while the response waits
        n = 0;
        while (!rsp.rvalid && n < HS_LIMIT)
        begin
            @(posedge SYS_clk);
            #1;
            n++;
        end
        if (!rsp.rvalid)
        begin
            $display("read of address %h got no response", addr);
            failures++;
        end
        data = rsp.rdata;
        resp = rsp.rresp;
        for (n = 0; n < hold; n++)
        begin
            @(posedge SYS_clk);
            #1;
            if (!rsp.rvalid)
            begin
                $display("rvalid dropped at %0t while rready was low", $time);
                failures++;
            end
            if (rsp.rdata !== data)
                report_mismatch("rdata held", data, rsp.rdata);
            if (rsp.rresp !== resp)
                report_mismatch("rresp held", resp, rsp.rresp);
        end
        req.rready = 1'b1;
        @(posedge SYS_clk);
        #1;
        req.rready = 1'b0;
    endtask

    initial
    begin : stimulus
        logic [31:0] rdata;
        logic [1:0]  resp;
        int          i;
        build_program();
        n_exec = run_model();
        repeat (2) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;
        axil_read(`CORE_MAP_CTRL, 0, rdata, resp);
        if (rdata !== 32'd0)
            report_mismatch("ctrl after reset", 32'd0, rdata);
        if (resp !== RESP_OKAY)
            report_mismatch("rresp ctrl", RESP_OKAY, resp);
        for (i = 0; i < prog_len; i++)
        begin
            axil_write(`CORE_MAP_IMEM + 4 * i, prog[i], resp);
            if (resp !== RESP_OKAY)
                report_mismatch($sformatf("bresp imem[%0d]", i), RESP_OKAY, resp);
        end
        axil_read(`CORE_MAP_REGS, 0, rdata, resp);   // r0 through region 0
        if (resp !== RESP_OKAY)
            report_mismatch("rresp reg[0]", RESP_OKAY, resp);
        if (rdata !== 32'd0)
            report_mismatch("reg[0]", 32'd0, rdata);
        axil_write(`CORE_MAP_CTRL, 32'd1, resp);
        if (resp !== RESP_OKAY)
            report_mismatch("bresp ctrl start", RESP_OKAY, resp);
        axil_read(`CORE_MAP_CTRL, 0, rdata, resp);
        if (rdata !== 32'd1)
            report_mismatch("ctrl running", 32'd1, rdata);
        // dropped while running, or the join marker of the last block changes
        axil_write(`CORE_MAP_IMEM + 4 * (prog_len - 2),
                   encode_i(OP_ADDI, 5'd5, 5'd0, 16'h7777), resp);
        if (resp !== RESP_SLVERR)
            report_mismatch("bresp imem while running", RESP_SLVERR, resp);
        axil_read(12'h600, 5, rdata, resp);   // unmapped
        if (resp !== RESP_SLVERR)
            report_mismatch("rresp unmapped", RESP_SLVERR, resp);
        repeat (6 * n_exec + 16) @(posedge SYS_clk);
        axil_write(`CORE_MAP_CTRL, 32'd0, resp);
        if (resp !== RESP_OKAY)
            report_mismatch("bresp ctrl stop", RESP_OKAY, resp);
        -> state_ready;
    end

    initial
    begin : compare
        logic [31:0] rdata;
        logic [1:0]  resp;
        int          i;
        @(state_ready);
        for (i = 0; i < 32; i++)
        begin
            axil_read(`CORE_MAP_REGS + 4 * i, 0, rdata, resp);
            if (resp !== RESP_OKAY)
                report_mismatch($sformatf("rresp reg[%0d]", i), RESP_OKAY, resp);
            if (rdata !== exp_regs[i])
                report_mismatch($sformatf("reg[%0d]", i), exp_regs[i], rdata);
        end
        for (i = 0; i < `CORE_DMEM_WORDS; i++)
        begin
            if (exp_dmem_set[i])
            begin
                axil_read(`CORE_MAP_DMEM + 4 * i, 0, rdata, resp);
                if (resp !== RESP_OKAY)
                    report_mismatch($sformatf("rresp dmem[%0d]", i), RESP_OKAY, resp);
                if (rdata !== exp_dmem[i])
                    report_mismatch($sformatf("dmem[%0d]", i), exp_dmem[i], rdata);
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin : watchdog
        wait (n_exec > 0);
        repeat (20 * prog_len * 6) @(posedge SYS_clk);
        $display("timeout: run did not finish within %0d cycles", 20 * prog_len * 6);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
+incdir+verif
src/isa_pkg.sv
src/pipe_pkg.sv
src/stage_reg.sv
src/axil_host_port.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/memory_unit.sv
src/mips_core_top.sv
verif/tb_mips_core.sv
